//--- alu_pkg.sv
package alu_pkg;

    parameter int XLEN     = 32;
    parameter int ROB_BITS = 4;

    typedef logic [XLEN-1:0]     xlen_t;
    typedef logic [ROB_BITS-1:0] rob_id_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SLT
    } alu_op_e;

    typedef enum logic [2:0] {
        BR_BEQ,
        BR_BNE,
        BR_BLT,
        BR_JAL
    } br_op_e;

    // is_branch selects the view
    typedef union packed {
        alu_op_e alu;
        br_op_e  br;
    } op_u;

    typedef struct packed {
        logic    ready;
        rob_id_t tag;
        xlen_t   value;
    } src_t;

    typedef struct packed {
        logic    is_branch;
        op_u     op;
        xlen_t   pc;
        xlen_t   imm;
        rob_id_t rob_id;
        src_t    src0;
        src_t    src1;
    } uop_t;

    typedef struct packed {
        rob_id_t rob_id;
        xlen_t   wdata;
        logic    jump;
        xlen_t   target;
    } cdb_t;

    // tag match against two broadcast ports
    function automatic src_t wake_src(
        input src_t src,
        input logic v0,
        input cdb_t c0,
        input logic v1,
        input cdb_t c1
    );
        src_t res;
        res = src;
        if (!src.ready && v0 && (c0.rob_id == src.tag)) begin
            res.ready = 1'b1;
            res.value = c0.wdata;
        end else if (!src.ready && v1 && (c1.rob_id == src.tag)) begin
            res.ready = 1'b1;
            res.value = c1.wdata;
        end
        return res;
    endfunction

endpackage

//--- issue_if.sv
`timescale 1ns/1ps

interface issue_if import alu_pkg::*; ();

    logic    valid;
    logic    ready;
    logic    is_branch;
    op_u     op;
    xlen_t   pc;
    xlen_t   imm;
    rob_id_t rob_id;
    // resolved operand values
    xlen_t   op0;
    xlen_t   op1;

    modport source (
        output valid, is_branch, op, pc, imm, rob_id, op0, op1,
        input  ready
    );

    modport sink (
        input  valid, is_branch, op, pc, imm, rob_id, op0, op1,
        output ready
    );

endinterface

//--- iq_entry.sv
`timescale 1ns/1ps

module iq_entry import alu_pkg::*; (
    input  logic clk,
    input  logic rst_n_i,
    input  logic flush_i,

    input  logic write_i,
    input  uop_t uop_i,
    input  logic issue_i,

    input  logic wake0_valid_i,
    input  cdb_t wake0_i,
    input  logic wake1_valid_i,
    input  cdb_t wake1_i,

    output logic valid_o,
    output logic ready_o,
    output uop_t uop_o
);

    logic valid_q;
    uop_t uop_q;

    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_i) begin
            valid_q <= 1'b0;
        end else if (write_i) begin
            valid_q <= 1'b1;
        end else if (issue_i) begin
            valid_q <= 1'b0;
        end
    end

    // incoming uop is already woken by the allocator
    always_ff @(posedge clk) begin
        if (write_i) begin
            uop_q <= uop_i;
        end else begin
            uop_q.src0 <= wake_src(uop_q.src0, wake0_valid_i, wake0_i,
                                   wake1_valid_i, wake1_i);
            uop_q.src1 <= wake_src(uop_q.src1, wake0_valid_i, wake0_i,
                                   wake1_valid_i, wake1_i);
        end
    end

    assign valid_o = valid_q;
    assign ready_o = valid_q && uop_q.src0.ready && uop_q.src1.ready;
    assign uop_o   = uop_q;

endmodule

//--- iq_age_pick.sv
`timescale 1ns/1ps

module iq_age_pick #(
    parameter int IQ_SIZE  = 8,
    parameter int AGE_BITS = 3
) (
    input  logic               clk,
    input  logic               rst_n_i,
    input  logic               flush_i,
    input  logic [IQ_SIZE-1:0] ready_i,
    input  logic [IQ_SIZE-1:0] write_i,
    input  logic               issue_en_i,
    output logic [IQ_SIZE-1:0] grant_o,
    output logic               grant_valid_o
);

    logic [IQ_SIZE-1:0][AGE_BITS-1:0] age_q;
    logic [AGE_BITS-1:0]              best_age;
    logic                             found;

    // saturating age per slot
    always_ff @(posedge clk) begin
        for (int i = 0; i < IQ_SIZE; i++) begin
            if (!rst_n_i || flush_i) begin
                age_q[i] <= '0;
            end else if (write_i[i] || (issue_en_i && grant_o[i])) begin
                age_q[i] <= '0;
            end else if (age_q[i] != {AGE_BITS{1'b1}}) begin
                age_q[i] <= age_q[i] + 1'b1;
            end
        end
    end

    // walk down so that ties land on the lowest index
    always_comb begin
        best_age = '0;
        found    = 1'b0;
        grant_o  = '0;
        for (int i = IQ_SIZE - 1; i >= 0; i--) begin
            if (ready_i[i] && (!found || (age_q[i] >= best_age))) begin
                found      = 1'b1;
                best_age   = age_q[i];
                grant_o    = '0;
                grant_o[i] = 1'b1;
            end
        end
    end

    assign grant_valid_o = found;

endmodule

//--- alu_exec.sv
`timescale 1ns/1ps

module alu_exec import alu_pkg::*; (
    input  logic    clk,
    input  logic    rst_n_i,
    input  logic    flush_i,
    issue_if.sink   issue,
    output logic    out_valid_o,
    output cdb_t    out_cdb_o,
    input  logic    out_ready_i
);

    logic    valid_q;
    logic    is_branch_q;
    op_u     op_q;
    xlen_t   pc_q;
    xlen_t   imm_q;
    rob_id_t rob_id_q;
    xlen_t   op0_q;
    xlen_t   op1_q;

    // free now or drained on this edge
    assign issue.ready = !valid_q || out_ready_i;

    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_i) begin
            valid_q <= 1'b0;
        end else if (issue.ready) begin
            valid_q <= issue.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (issue.valid && issue.ready) begin
            is_branch_q <= issue.is_branch;
            op_q        <= issue.op;
            pc_q        <= issue.pc;
            imm_q       <= issue.imm;
            rob_id_q    <= issue.rob_id;
            op0_q       <= issue.op0;
            op1_q       <= issue.op1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // alu and branch evaluation

    always_comb begin
        out_cdb_o        = '0;
        out_cdb_o.rob_id = rob_id_q;
        if (is_branch_q) begin
            out_cdb_o.wdata  = pc_q + 32'd4;
            out_cdb_o.target = pc_q + imm_q;
            case (op_q.br)
                BR_BEQ:  out_cdb_o.jump = (op0_q == op1_q);
                BR_BNE:  out_cdb_o.jump = (op0_q != op1_q);
                BR_BLT:  out_cdb_o.jump = ($signed(op0_q) < $signed(op1_q));
                BR_JAL:  out_cdb_o.jump = 1'b1;
                default: out_cdb_o.jump = 1'b0;
            endcase
        end else begin
            case (op_q.alu)
                ALU_ADD: out_cdb_o.wdata = op0_q + op1_q;
                ALU_SUB: out_cdb_o.wdata = op0_q - op1_q;
                ALU_AND: out_cdb_o.wdata = op0_q & op1_q;
                ALU_OR:  out_cdb_o.wdata = op0_q | op1_q;
                ALU_XOR: out_cdb_o.wdata = op0_q ^ op1_q;
                ALU_SLL: out_cdb_o.wdata = op0_q << op1_q[4:0];
                ALU_SRL: out_cdb_o.wdata = op0_q >> op1_q[4:0];
                ALU_SLT: out_cdb_o.wdata = {31'd0, $signed(op0_q) < $signed(op1_q)};
                default: out_cdb_o.wdata = '0;
            endcase
        end
    end

    assign out_valid_o = valid_q;

endmodule

//--- cdb_fifo.sv
`timescale 1ns/1ps

module cdb_fifo import alu_pkg::*; (
    input  logic clk,
    input  logic rst_n_i,
    input  logic flush_i,
    input  logic in_valid_i,
    input  cdb_t in_cdb_i,
    output logic in_ready_o,
    output logic out_valid_o,
    output cdb_t out_cdb_o,
    input  logic out_ready_i
);

    cdb_t       mem_q [2];
    logic [1:0] cnt_q;
    logic       rd_ptr_q;
    logic       wr_ptr_q;
    logic       empty;
    logic       push;
    logic       pop;

    assign empty       = (cnt_q == 2'd0);
    assign in_ready_o  = (cnt_q != 2'd2);
    assign out_valid_o = !empty || in_valid_i;
    // bypass when nothing is stored
    assign out_cdb_o   = empty ? in_cdb_i : mem_q[rd_ptr_q];

    assign push = in_valid_i && in_ready_o && !(empty && out_ready_i);
    assign pop  = !empty && out_ready_i;

    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_i) begin
            cnt_q    <= 2'd0;
            rd_ptr_q <= 1'b0;
            wr_ptr_q <= 1'b0;
        end else begin
            cnt_q    <= cnt_q + {1'b0, push} - {1'b0, pop};
            rd_ptr_q <= rd_ptr_q ^ pop;
            wr_ptr_q <= wr_ptr_q ^ push;
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem_q[wr_ptr_q] <= in_cdb_i;
        end
    end

endmodule

//--- alu_iq.sv
`timescale 1ns/1ps

module alu_iq import alu_pkg::*; #(
    parameter int IQ_SIZE  = 8,
    parameter int AGE_BITS = 3
) (
    input  logic clk,
    input  logic rst_n_i,
    input  logic flush_i,

    input  logic dispatch_valid_i,
    input  uop_t dispatch_uop_i,
    output logic dispatch_ready_o,

    input  logic ext_cdb_valid_i,
    input  cdb_t ext_cdb_i,

    output logic cdb_valid_o,
    output cdb_t cdb_o,
    input  logic cdb_ready_i
);

    logic [IQ_SIZE-1:0] slot_valid;
    logic [IQ_SIZE-1:0] slot_ready;
    logic [IQ_SIZE-1:0] free_sel;
    logic [IQ_SIZE-1:0] slot_write;
    logic [IQ_SIZE-1:0] grant;
    uop_t               slot_uop [IQ_SIZE];
    logic               grant_valid;
    logic               issue_fire;
    logic               cdb_fire;
    uop_t               disp_uop;
    uop_t               pick_uop;
    logic               res_valid;
    cdb_t               res_cdb;
    logic               res_ready;

    issue_if iss ();

    // own results count only when they leave
    assign cdb_fire = cdb_valid_o && cdb_ready_i;

    //////////////////////////////////////////////////////////////////////
    // allocation

    always_comb begin
        free_sel = '0;
        for (int i = IQ_SIZE - 1; i >= 0; i--) begin
            if (!slot_valid[i]) begin
                free_sel    = '0;
                free_sel[i] = 1'b1;
            end
        end
    end

    assign dispatch_ready_o = |(~slot_valid);
    assign slot_write       = free_sel & {IQ_SIZE{dispatch_valid_i}};

    // catch a broadcast landing in the dispatch cycle
    always_comb begin
        disp_uop      = dispatch_uop_i;
        disp_uop.src0 = wake_src(dispatch_uop_i.src0, ext_cdb_valid_i, ext_cdb_i,
                                 cdb_fire, cdb_o);
        disp_uop.src1 = wake_src(dispatch_uop_i.src1, ext_cdb_valid_i, ext_cdb_i,
                                 cdb_fire, cdb_o);
    end

    //////////////////////////////////////////////////////////////////////
    // entries and picker

    for (genvar g = 0; g < IQ_SIZE; g++) begin : g_entry
        iq_entry i_entry (
            .clk           (clk),
            .rst_n_i       (rst_n_i),
            .flush_i       (flush_i),
            .write_i       (slot_write[g]),
            .uop_i         (disp_uop),
            .issue_i       (grant[g] && issue_fire),
            .wake0_valid_i (ext_cdb_valid_i),
            .wake0_i       (ext_cdb_i),
            .wake1_valid_i (cdb_fire),
            .wake1_i       (cdb_o),
            .valid_o       (slot_valid[g]),
            .ready_o       (slot_ready[g]),
            .uop_o         (slot_uop[g])
        );
    end

    iq_age_pick #(
        .IQ_SIZE  (IQ_SIZE),
        .AGE_BITS (AGE_BITS)
    ) i_pick (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .flush_i       (flush_i),
        .ready_i       (slot_ready),
        .write_i       (slot_write),
        .issue_en_i    (issue_fire),
        .grant_o       (grant),
        .grant_valid_o (grant_valid)
    );

    always_comb begin
        pick_uop = '0;
        for (int i = 0; i < IQ_SIZE; i++) begin
            if (grant[i]) begin
                pick_uop = slot_uop[i];
            end
        end
    end

    assign iss.valid     = grant_valid;
    assign iss.is_branch = pick_uop.is_branch;
    assign iss.op        = pick_uop.op;
    assign iss.pc        = pick_uop.pc;
    assign iss.imm       = pick_uop.imm;
    assign iss.rob_id    = pick_uop.rob_id;
    assign iss.op0       = pick_uop.src0.value;
    assign iss.op1       = pick_uop.src1.value;
    assign issue_fire    = iss.valid && iss.ready;

    //////////////////////////////////////////////////////////////////////
    // execute and result buffer

    alu_exec i_exec (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .flush_i     (flush_i),
        .issue       (iss.sink),
        .out_valid_o (res_valid),
        .out_cdb_o   (res_cdb),
        .out_ready_i (res_ready)
    );

    cdb_fifo i_fifo (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .flush_i     (flush_i),
        .in_valid_i  (res_valid),
        .in_cdb_i    (res_cdb),
        .in_ready_o  (res_ready),
        .out_valid_o (cdb_valid_o),
        .out_cdb_o   (cdb_o),
        .out_ready_i (cdb_ready_i)
    );

endmodule

//--- tb_alu_iq.sv
`timescale 1ns/1ps

module tb_alu_iq import alu_pkg::*; ();

    localparam int IQ_SIZE   = 8;
    localparam int AGE_BITS  = 3;
    localparam int WAIT_MAX  = 1000;
    localparam int DRAIN_MAX = 4000;

    logic clk;
    logic rst_n_i;
    logic flush_i;
    logic dispatch_valid_i;
    uop_t dispatch_uop_i;
    logic dispatch_ready_o;
    logic ext_cdb_valid_i;
    cdb_t ext_cdb_i;
    logic cdb_valid_o;
    cdb_t cdb_o;
    logic cdb_ready_i;

    integer seed = 32'hde68;

    // scoreboard indexed by rob id
    cdb_t expected [16];
    int   disp_cnt [16];
    int   done_cnt [16];

    alu_iq #(
        .IQ_SIZE  (IQ_SIZE),
        .AGE_BITS (AGE_BITS)
    ) i_dut (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .flush_i          (flush_i),
        .dispatch_valid_i (dispatch_valid_i),
        .dispatch_uop_i   (dispatch_uop_i),
        .dispatch_ready_o (dispatch_ready_o),
        .ext_cdb_valid_i  (ext_cdb_valid_i),
        .ext_cdb_i        (ext_cdb_i),
        .cdb_valid_o      (cdb_valid_o),
        .cdb_o            (cdb_o),
        .cdb_ready_i      (cdb_ready_i)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // helpers

    task automatic stop_fail(input string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1, "simulation stopped on first failure");
    endtask

    task automatic compare_cdb(input cdb_t got, input cdb_t exp);
        string got_s;
        if (got !== exp) begin
            got_s = $sformatf("rob %0d got wdata %h jump %b target %h",
                              got.rob_id, got.wdata, got.jump, got.target);
            stop_fail($sformatf("error at %0t: %s, expected wdata %h jump %b target %h",
                                $time, got_s, exp.wdata, exp.jump, exp.target));
        end
    endtask

    task automatic compare_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_fail($sformatf("error at %0t: %s is %b, expected %b",
                                $time, name, got, exp));
        end
    endtask

    // step to the next falling edge and draw new back-pressure
    task automatic tick();
        @(negedge clk);
        cdb_ready_i = ($random(seed) & 32'sd3) != 0;
    endtask

    function automatic int count_pending();
        int n;
        n = 0;
        for (int r = 0; r < 16; r++) begin
            if (disp_cnt[r] != done_cnt[r]) begin
                n++;
            end
        end
        return n;
    endfunction

    task automatic dispatch_uop(input uop_t uop, input cdb_t exp);
        int n;
        n = 0;
        // a rob id is reused only after its last result has left
        while (disp_cnt[uop.rob_id] != done_cnt[uop.rob_id]) begin
            tick();
            n++;
            if (n > WAIT_MAX) begin
                stop_fail($sformatf("timeout waiting for rob id %0d to retire", uop.rob_id));
            end
        end
        expected[uop.rob_id] = exp;
        disp_cnt[uop.rob_id] = disp_cnt[uop.rob_id] + 1;
        dispatch_valid_i = 1'b1;
        dispatch_uop_i   = uop;
        n = 0;
        while (!dispatch_ready_o) begin
            tick();
            n++;
            if (n > WAIT_MAX) begin
                stop_fail("timeout waiting for dispatch_ready_o");
            end
        end
        tick();
        dispatch_valid_i = 1'b0;
    endtask

    //////////////////////////////////////////////////////////////////////
    // result monitor

    always @(posedge clk) begin
        if (rst_n_i && !flush_i && cdb_valid_o && cdb_ready_i) begin
            if (disp_cnt[cdb_o.rob_id] == done_cnt[cdb_o.rob_id]) begin
                stop_fail($sformatf("error at %0t: unexpected result for rob id %0d",
                                    $time, cdb_o.rob_id));
            end else begin
                compare_cdb(cdb_o, expected[cdb_o.rob_id]);
                done_cnt[cdb_o.rob_id] = done_cnt[cdb_o.rob_id] + 1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // trace driven stimulus

    initial begin
        int          fd;
        int          code;
        int          n;
        string       kind;
        string       line;
        logic [31:0] fld [14];
        uop_t        uop;
        cdb_t        exp;

        rst_n_i          = 1'b0;
        flush_i          = 1'b0;
        dispatch_valid_i = 1'b0;
        dispatch_uop_i   = '0;
        ext_cdb_valid_i  = 1'b0;
        ext_cdb_i        = '0;
        cdb_ready_i      = 1'b1;
        for (int r = 0; r < 16; r++) begin
            expected[r] = '0;
            disp_cnt[r] = 0;
        end
        repeat (8) tick();
        rst_n_i = 1'b1;
        tick();
        compare_bit("dispatch_ready_o", dispatch_ready_o, 1'b1);
        compare_bit("cdb_valid_o", cdb_valid_o, 1'b0);

        fd = $fopen("alu_iq_trace.txt", "r");
        if (fd == 0) begin
            stop_fail("could not open alu_iq_trace.txt for reading");
        end
        while (!$feof(fd)) begin
            code = $fscanf(fd, " %s", kind);
            if (code != 1) begin
                break;
            end
            if (kind == "#") begin
                code = $fgets(line, fd);
            end else if (kind == "D") begin
                code = $fscanf(fd, " %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                               fld[0], fld[1], fld[2], fld[3], fld[4], fld[5], fld[6],
                               fld[7], fld[8], fld[9], fld[10], fld[11], fld[12], fld[13]);
                if (code != 14) begin
                    stop_fail("malformed dispatch line in trace file");
                end
                uop            = '0;
                uop.rob_id     = fld[0][3:0];
                uop.is_branch  = fld[1][0];
                uop.op.alu     = alu_op_e'(fld[2][2:0]);
                uop.pc         = fld[3];
                uop.imm        = fld[4];
                uop.src0.ready = fld[5][0];
                uop.src0.tag   = fld[6][3:0];
                uop.src0.value = fld[7];
                uop.src1.ready = fld[8][0];
                uop.src1.tag   = fld[9][3:0];
                uop.src1.value = fld[10];
                exp.rob_id     = fld[0][3:0];
                exp.wdata      = fld[11];
                exp.jump       = fld[12][0];
                exp.target     = fld[13];
                dispatch_uop(uop, exp);
            end else if (kind == "E") begin
                code = $fscanf(fd, " %h %h", fld[0], fld[1]);
                if (code != 2) begin
                    stop_fail("malformed broadcast line in trace file");
                end
                ext_cdb_valid_i  = 1'b1;
                ext_cdb_i        = '0;
                ext_cdb_i.rob_id = fld[0][3:0];
                ext_cdb_i.wdata  = fld[1];
                tick();
                ext_cdb_valid_i  = 1'b0;
            end else if (kind == "F") begin
                flush_i     = 1'b1;
                cdb_ready_i = 1'b0;
                tick();
                flush_i = 1'b0;
                // whatever was in flight is gone
                for (int r = 0; r < 16; r++) begin
                    disp_cnt[r] = done_cnt[r];
                end
            end else if (kind == "W") begin
                code = $fscanf(fd, " %d %d", fld[0], fld[1]);
                if (code != 2) begin
                    stop_fail("malformed wait line in trace file");
                end
                repeat (fld[0]) tick();
                compare_bit("dispatch_ready_o", dispatch_ready_o, fld[1][0]);
            end else begin
                stop_fail($sformatf("unknown line kind %s in trace file", kind));
            end
        end
        $fclose(fd);

        n = 0;
        while (count_pending() != 0 || cdb_valid_o) begin
            tick();
            n++;
            if (n > DRAIN_MAX) begin
                stop_fail($sformatf("timeout waiting for %0d results to retire",
                                    count_pending()));
            end
        end
        $display("Result: PASSED");
        $finish;
    end

endmodule

//--- alu_iq_trace.txt
# D rob is_br op pc imm s0_rdy s0_tag s0_val s1_rdy s1_tag s1_val exp_wdata exp_jump exp_target
# E rob wdata | F | W cycles expected_dispatch_ready   (all D and E fields hex)
D 0 0 0 00000000 00000000 1 0 00000005 1 0 00000003 00000008 0 00000000
D 1 0 1 00000000 00000000 1 0 0000000a 1 0 00000003 00000007 0 00000000
D 2 0 2 00000000 00000000 1 0 f0f0f0f0 1 0 0ff00ff0 00f000f0 0 00000000
D 3 0 3 00000000 00000000 1 0 f0000000 1 0 0000000f f000000f 0 00000000
D 4 0 4 00000000 00000000 1 0 ffff0000 1 0 0f0f0f0f f0f00f0f 0 00000000
D 5 0 5 00000000 00000000 1 0 00000001 1 0 00000024 00000010 0 00000000
D 6 0 6 00000000 00000000 1 0 80000000 1 0 0000001f 00000001 0 00000000
D 7 0 7 00000000 00000000 1 0 ffffffff 1 0 00000001 00000001 0 00000000
D 8 1 0 00001000 00000040 1 0 00000007 1 0 00000007 00001004 1 00001040
D 9 1 1 00002000 fffffff0 1 0 00000005 1 0 00000005 00002004 0 00001ff0
D a 1 2 00000100 00000010 1 0 00000003 1 0 fffffffe 00000104 0 00000110
D b 1 3 00000200 00000100 1 0 00000000 1 0 00000000 00000204 1 00000300
W 4 1
D c 0 0 00000000 00000000 0 e 00000000 1 0 00000010 00000030 0 00000000
W 3 1
E e 00000020
D d 0 0 00000000 00000000 1 0 00000100 1 0 00000001 00000101 0 00000000
D f 0 1 00000000 00000000 0 d 00000000 1 0 00000001 00000100 0 00000000
D 0 0 0 00000000 00000000 0 e 00000000 1 0 00000000 00000007 0 00000000
D 1 0 0 00000000 00000000 0 e 00000000 1 0 00000001 00000008 0 00000000
D 2 0 0 00000000 00000000 0 e 00000000 1 0 00000002 00000009 0 00000000
D 3 0 0 00000000 00000000 0 e 00000000 1 0 00000003 0000000a 0 00000000
D 4 0 0 00000000 00000000 0 e 00000000 1 0 00000004 0000000b 0 00000000
D 5 0 0 00000000 00000000 0 e 00000000 1 0 00000005 0000000c 0 00000000
D 6 0 0 00000000 00000000 0 e 00000000 1 0 00000006 0000000d 0 00000000
D 7 0 0 00000000 00000000 0 e 00000000 1 0 00000007 0000000e 0 00000000
W 2 0
E e 00000007
W 3 1
D 8 0 0 00000000 00000000 0 e 00000000 1 0 00000006 00000000 0 00000000
D 9 0 0 00000000 00000000 0 e 00000000 1 0 00000009 00000000 0 00000000
F
E e 00000001
W 6 1
D 8 0 0 00000000 00000000 1 0 00000002 1 0 00000002 00000004 0 00000000
D 9 0 4 00000000 00000000 1 0 0000000c 1 0 0000000a 00000006 0 00000000
W 4 1

//--- vlog.f
alu_pkg.sv
issue_if.sv
iq_entry.sv
iq_age_pick.sv
alu_exec.sv
cdb_fifo.sv
alu_iq.sv
tb_alu_iq.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the alu_iq testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --top-module tb_alu_iq -f vlog.f -o sim_tb_alu_iq
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_tb_alu_iq > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Result: FAILED" "$LOG"; then
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
exit 0
